/* hdl/cpu_pkg.sv */
package cpu_pkg;

    // Status register bit positions
    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_I = 2;
    localparam int FLAG_D = 3;                  // Stored only, no decimal mode
    localparam int FLAG_V = 6;
    localparam int FLAG_N = 7;

    // ------------------------------------------------------------------
    // Microsequencer states
    typedef enum logic [4:0] {
        FETCH = 5'h00,                          // Opcode fetch, PC step
        NDX0  = 5'h01,                          // (ind,X) pointer + X
        NDX1  = 5'h02,                          // (ind,X) low byte
        NDX2  = 5'h03,                          // (ind,X) high byte
        NDY0  = 5'h04,                          // (ind),Y pointer
        NDY1  = 5'h05,                          // (ind),Y low byte + Y
        NDY2  = 5'h06,                          // (ind),Y high byte + carry
        ZP    = 5'h07,
        ZPX   = 5'h08,
        ZPY   = 5'h09,
        ABS0  = 5'h0A,                          // Low address byte
        ABS1  = 5'h0B,                          // High address byte or JMP
        ABX0  = 5'h0C,
        ABX1  = 5'h0D,
        ABY0  = 5'h0E,
        ABY1  = 5'h0F,
        LAT1  = 5'h10,                          // One delay cycle
        EXEC  = 5'h11,                          // Execute and write back
        REL   = 5'h15,                          // Branch offset
        REL1  = 5'h16,                          // Page cross delay
        REL2  = 5'h17,                          // Taken branch delay
        LATX  = 5'h18                           // (ind,X) pointer carry check
    } ms_e;

    // ALU operations, low codes follow opcode bits 7:5
    typedef enum logic [3:0] {
        ALU_OR     = 4'h0,
        ALU_AND    = 4'h1,
        ALU_EOR    = 4'h2,
        ALU_ADC    = 4'h3,
        ALU_PASS_A = 4'h4,                      // Stores
        ALU_PASS_B = 4'h5,                      // Loads and transfers
        ALU_CMP    = 4'h6,
        ALU_SBC    = 4'h7,
        ALU_FLAGOP = 4'hC,                      // Set or clear one flag
        ALU_BIT    = 4'hD,
        ALU_DEC    = 4'hE,
        ALU_INC    = 4'hF
    } alu_op_e;

    // A port: A, X, Y, zero.  B port: operand, X, Y, S
    typedef enum logic [1:0] {
        SEL_AD = 2'b00,
        SEL_X  = 2'b01,
        SEL_Y  = 2'b10,
        SEL_ZS = 2'b11
    } reg_sel_e;

    // ------------------------------------------------------------------
    typedef struct packed {
        alu_op_e  alu_op;
        reg_sel_e ra;                           // A port, also write target
        reg_sel_e rb;                           // B port
        logic     wr;                           // Register write
        logic     fw;                           // Flag write
        logic     sw;                           // Stack pointer write
        logic     acc;                          // A in place of data byte
        logic     br;                           // Branch condition true
        logic     st;                           // Memory store
    } exec_ctrl_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        we;
    } mem_req_t;

endpackage

/* hdl/cpu_alu.sv */
module cpu_alu (
    input  logic [7:0]       a,
    input  logic [7:0]       b,
    input  cpu_pkg::alu_op_e op,
    input  logic [7:0]       p,
    input  logic [2:0]       sub,               // Opcode bits 7:5
    output logic [7:0]       result,
    output logic [7:0]       flags
);

    logic [8:0] sum;                            // Adder with carry out
    logic [7:0] addend;                         // b or ~b
    logic       cin;
    logic       nz_upd;                         // N and Z follow the result
    logic [7:0] nz_src;

    // Shared adder, subtraction as a + ~b + carry
    always_comb begin
        addend = (op == cpu_pkg::ALU_ADC) ? b : ~b;
        cin    = (op == cpu_pkg::ALU_CMP) ? 1'b1 : p[cpu_pkg::FLAG_C];   // Compare ignores C
        sum    = {1'b0, a} + {1'b0, addend} + {8'd0, cin};
    end

    always_comb begin
        result = a;
        flags  = p;
        nz_upd = 1'b1;
        case (op)
            cpu_pkg::ALU_OR:  result = a | b;
            cpu_pkg::ALU_AND: result = a & b;
            cpu_pkg::ALU_EOR: result = a ^ b;
            cpu_pkg::ALU_ADC,
            cpu_pkg::ALU_SBC: begin
                result               = sum[7:0];
                flags[cpu_pkg::FLAG_C] = sum[8];           // Carry, or no borrow
                flags[cpu_pkg::FLAG_V] = (a[7] == addend[7]) && (sum[7] != a[7]);
            end
            cpu_pkg::ALU_CMP: flags[cpu_pkg::FLAG_C] = sum[8];   // Result byte unused
            cpu_pkg::ALU_PASS_A: nz_upd = 1'b0;                  // Store, flags kept
            cpu_pkg::ALU_PASS_B: result = b;
            cpu_pkg::ALU_FLAGOP: begin
                nz_upd = 1'b0;
                case (sub[2:1])
                    2'b00:   flags[cpu_pkg::FLAG_C] = sub[0];    // CLC, SEC
                    2'b01:   flags[cpu_pkg::FLAG_I] = sub[0];    // CLI, SEI
                    2'b10:   flags[cpu_pkg::FLAG_V] = 1'b0;      // CLV only
                    default: flags[cpu_pkg::FLAG_D] = sub[0];    // CLD, SED
                endcase
            end
            cpu_pkg::ALU_BIT: begin
                nz_upd                 = 1'b0;
                flags[cpu_pkg::FLAG_N] = b[7];
                flags[cpu_pkg::FLAG_V] = b[6];
                flags[cpu_pkg::FLAG_Z] = ~|(a & b);
            end
            cpu_pkg::ALU_DEC: result = b - 8'd1;
            cpu_pkg::ALU_INC: result = b + 8'd1;
            default:          nz_upd = 1'b0;
        endcase

        // N and Z from the compare difference or the result
        nz_src = (op == cpu_pkg::ALU_CMP) ? sum[7:0] : result;
        if (nz_upd) begin
            flags[cpu_pkg::FLAG_N] = nz_src[7];
            flags[cpu_pkg::FLAG_Z] = ~|nz_src;
        end
    end

endmodule

/* hdl/cpu_exec_decode.sv */
module cpu_exec_decode (
    input  logic [7:0]          opcode,
    input  cpu_pkg::ms_e        state,
    input  logic [7:0]          p,
    output cpu_pkg::exec_ctrl_t ctrl
);

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = cpu_pkg::alu_op_e'({1'b0, opcode[7:5]});   // Group one op
        ctrl.ra     = cpu_pkg::SEL_AD;
        ctrl.rb     = cpu_pkg::SEL_AD;

        // Branch condition, flag by bits 7:6 against bit 5
        case (opcode[7:6])
            2'b00:   ctrl.br = (p[cpu_pkg::FLAG_N] == opcode[5]);
            2'b01:   ctrl.br = (p[cpu_pkg::FLAG_V] == opcode[5]);
            2'b10:   ctrl.br = (p[cpu_pkg::FLAG_C] == opcode[5]);
            default: ctrl.br = (p[cpu_pkg::FLAG_Z] == opcode[5]);
        endcase

        // ------------------------------------------------------------------
        if (state == cpu_pkg::EXEC) begin
            casez (opcode)
                8'b100_???_01: ctrl.st = 1'b1;                   // STA
                8'b110_???_01: ctrl.fw = 1'b1;                   // CMP
                8'b???_???_01: begin                             // ORA AND EOR ADC LDA SBC
                    ctrl.wr = 1'b1;
                    ctrl.fw = 1'b1;
                end
                8'b100_??1_00: begin                             // STY
                    ctrl.ra = cpu_pkg::SEL_Y;
                    ctrl.st = 1'b1;
                end
                8'b100_??1_10: begin                             // STX
                    ctrl.ra = cpu_pkg::SEL_X;
                    ctrl.st = 1'b1;
                end
                8'b101_??1_00,
                8'b101_000_00: begin                             // LDY
                    ctrl.ra = cpu_pkg::SEL_Y;
                    ctrl.wr = 1'b1;
                    ctrl.fw = 1'b1;
                end
                8'b101_??1_10,
                8'b101_000_10: begin                             // LDX
                    ctrl.ra = cpu_pkg::SEL_X;
                    ctrl.wr = 1'b1;
                    ctrl.fw = 1'b1;
                end
                8'b110_??1_00,
                8'b110_000_00: begin                             // CPY
                    ctrl.ra = cpu_pkg::SEL_Y;
                    ctrl.fw = 1'b1;
                end
                8'b111_??1_00,
                8'b111_000_00: begin                             // CPX
                    ctrl.alu_op = cpu_pkg::ALU_CMP;
                    ctrl.ra     = cpu_pkg::SEL_X;
                    ctrl.fw     = 1'b1;
                end
                8'b001_0?1_00: begin                             // BIT
                    ctrl.alu_op = cpu_pkg::ALU_BIT;
                    ctrl.fw     = 1'b1;
                end
                8'b1??_010_?0: begin                             // DEY DEX INY INX TAY TAX TXA
                    ctrl.alu_op = (opcode == 8'hC8 || opcode == 8'hE8) ? cpu_pkg::ALU_INC :
                                  (opcode == 8'h88 || opcode == 8'hCA) ? cpu_pkg::ALU_DEC :
                                  cpu_pkg::ALU_PASS_B;
                    ctrl.ra     = opcode[1] ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;
                    ctrl.rb     = opcode[1] ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;
                    ctrl.acc    = (opcode[7:5] == 3'b101);       // TAX TAY read A
                    ctrl.wr     = 1'b1;
                    ctrl.fw     = 1'b1;
                    if (opcode[7:5] == 3'b101) begin
                        ctrl.rb = cpu_pkg::SEL_AD;
                    end else if (opcode == 8'h8A) begin          // TXA
                        ctrl.ra = cpu_pkg::SEL_AD;
                    end
                    if (opcode == 8'hE8 || opcode == 8'hC8) begin
                        ctrl.ra = (opcode == 8'hE8) ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;
                        ctrl.rb = ctrl.ra;
                    end
                end
                8'b100_110_00: begin                             // TYA
                    ctrl.alu_op = cpu_pkg::ALU_PASS_B;
                    ctrl.rb     = cpu_pkg::SEL_Y;
                    ctrl.wr     = 1'b1;
                    ctrl.fw     = 1'b1;
                end
                8'b100_110_10: begin                             // TXS, no flags
                    ctrl.alu_op = cpu_pkg::ALU_PASS_B;
                    ctrl.rb     = cpu_pkg::SEL_X;
                    ctrl.sw     = 1'b1;
                end
                8'b101_110_10: begin                             // TSX
                    ctrl.alu_op = cpu_pkg::ALU_PASS_B;
                    ctrl.ra     = cpu_pkg::SEL_X;
                    ctrl.rb     = cpu_pkg::SEL_ZS;
                    ctrl.wr     = 1'b1;
                    ctrl.fw     = 1'b1;
                end
                8'b???_110_00: begin                             // CLC SEC CLI SEI CLV CLD SED
                    ctrl.alu_op = cpu_pkg::ALU_FLAGOP;
                    ctrl.fw     = 1'b1;
                end
                default: ctrl.fw = 1'b0;                         // Branches, JMP, reserved
            endcase
        end
    end

endmodule

/* hdl/cpu_core.sv */
module cpu_core #(
    parameter logic [15:0] RESET_PC = 16'h0400
) (
    input  logic              CLK,
    input  logic              rst,
    input  logic              ce,
    input  logic [7:0]        rdata,
    output cpu_pkg::mem_req_t bus,
    output logic              rd                // Operand read strobe
);

    logic [7:0]          a, x, y, s, p;         // Register file
    logic [15:0]         pc;
    cpu_pkg::ms_e        ms;                    // Micro-state
    logic [15:0]         ea;                    // Effective address
    logic [7:0]          tr;                    // Low address byte in flight
    logic [7:0]          opcode;
    logic                am;                    // Address from EA, else PC
    logic                hop;                   // Step past operand in EXEC
    logic                cout;                  // Index carry
    cpu_pkg::exec_ctrl_t ctrl;
    logic [7:0]          alu_a;
    logic [7:0]          alu_b;
    logic [7:0]          alu_res;
    logic [7:0]          alu_flags;

    // ------------------------------------------------------------------
    // Address arithmetic
    logic [15:0]  pc_inc;
    logic [15:0]  pc_rel;                       // Branch target
    logic         use_y;                        // Y indexed step
    logic [8:0]   idx_din;                      // Index + data byte
    logic [7:0]   hi_din;                       // High byte + carry
    logic [7:0]   ea_inc;                       // Wraps in zero page
    logic         incdec;                       // Reserved memory RMW opcodes
    cpu_pkg::ms_e lat_next;

    assign pc_inc   = pc + 16'd1;
    assign pc_rel   = pc_inc + {{8{rdata[7]}}, rdata};
    assign use_y    = (ms == cpu_pkg::ZPY) || (ms == cpu_pkg::ABY0) || (ms == cpu_pkg::NDY1);
    assign idx_din  = {1'b0, use_y ? y : x} + {1'b0, rdata};
    assign hi_din   = rdata + {7'd0, cout};
    assign ea_inc   = ea[7:0] + 8'd1;
    assign incdec   = ({opcode[7:6], opcode[2:0]} == 5'b11_110) ||
                      ({opcode[7], opcode[2:0]} == 4'b0_110);
    assign lat_next = (cout || (opcode[7:5] == 3'b100) || incdec) ? cpu_pkg::LAT1
                                                                   : cpu_pkg::EXEC;

    assign bus = '{addr: am ? ea : pc, wdata: alu_res, we: ctrl.st};   // Store in EXEC

    cpu_exec_decode u_decode (
        .opcode (opcode),
        .state  (ms),
        .p      (p),
        .ctrl   (ctrl)
    );

    // ALU port select
    always_comb begin
        case (ctrl.ra)
            cpu_pkg::SEL_AD: alu_a = a;
            cpu_pkg::SEL_X:  alu_a = x;
            cpu_pkg::SEL_Y:  alu_a = y;
            default:         alu_a = 8'h00;
        endcase
        case (ctrl.rb)
            cpu_pkg::SEL_AD: alu_b = ctrl.acc ? a : rdata;
            cpu_pkg::SEL_X:  alu_b = x;
            cpu_pkg::SEL_Y:  alu_b = y;
            default:         alu_b = s;
        endcase
    end

    cpu_alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .p      (p),
        .sub    (opcode[7:5]),
        .result (alu_res),
        .flags  (alu_flags)
    );

    // ------------------------------------------------------------------
    // Microsequencer
    always_ff @(posedge CLK) begin
        if (rst) begin
            ms   <= cpu_pkg::FETCH;
            pc   <= RESET_PC;
            am   <= 1'b0;
            hop  <= 1'b0;
            rd   <= 1'b0;
            cout <= 1'b0;
        end else if (ce) begin
            case (ms)
                cpu_pkg::FETCH: begin
                    pc     <= pc_inc;
                    rd     <= 1'b0;
                    opcode <= rdata;
                    hop    <= 1'b1;
                    casez (rdata)                                // Addressing mode entry
                        8'b???_000_?1: ms <= cpu_pkg::NDX0;
                        8'b???_010_?1,
                        8'b1??_000_?0: ms <= cpu_pkg::EXEC;      // Immediate
                        8'b???_100_?1: ms <= cpu_pkg::NDY0;
                        8'b???_110_?1: ms <= cpu_pkg::ABY0;
                        8'b???_001_??: ms <= cpu_pkg::ZP;
                        8'b???_011_??: ms <= cpu_pkg::ABS0;
                        8'b10?_101_1?: ms <= cpu_pkg::ZPY;       // LDX STX zp,Y
                        8'b???_101_??: ms <= cpu_pkg::ZPX;
                        8'b10?_111_1?: ms <= cpu_pkg::ABY0;      // LDX abs,Y
                        8'b???_111_??: ms <= cpu_pkg::ABX0;
                        8'b???_100_00: ms <= cpu_pkg::REL;
                        default: begin                           // Implied
                            ms  <= cpu_pkg::EXEC;
                            hop <= 1'b0;
                        end
                    endcase
                end
                cpu_pkg::NDX0: begin
                    ms   <= cpu_pkg::NDX1;
                    ea   <= {8'h00, idx_din[7:0]};
                    am   <= 1'b1;
                    cout <= idx_din[8];
                end
                cpu_pkg::NDX1: begin
                    ms <= cpu_pkg::NDX2;
                    ea <= {8'h00, ea_inc};
                    tr <= rdata;
                end
                cpu_pkg::NDX2: begin
                    ms <= cpu_pkg::LATX;
                    ea <= {rdata, tr};
                    rd <= 1'b1;
                end
                cpu_pkg::NDY0: begin
                    ms <= cpu_pkg::NDY1;
                    ea <= {8'h00, rdata};
                    am <= 1'b1;
                end
                cpu_pkg::NDY1: begin
                    ms   <= cpu_pkg::NDY2;
                    ea   <= {8'h00, ea_inc};
                    tr   <= idx_din[7:0];
                    cout <= idx_din[8];
                end
                cpu_pkg::ZP,
                cpu_pkg::ZPX,
                cpu_pkg::ZPY: begin
                    ms <= (ms == cpu_pkg::ZP) ? cpu_pkg::EXEC : cpu_pkg::LAT1;
                    ea <= {8'h00, (ms == cpu_pkg::ZP) ? rdata : idx_din[7:0]};
                    rd <= 1'b1;
                    am <= 1'b1;
                end
                cpu_pkg::ABS0: begin
                    ms <= cpu_pkg::ABS1;
                    tr <= rdata;
                    pc <= pc_inc;
                end
                cpu_pkg::ABS1: begin
                    if (opcode == 8'h4C) begin                   // JMP abs
                        pc <= {rdata, tr};
                        ms <= cpu_pkg::FETCH;
                    end else begin
                        ea <= {rdata, tr};
                        am <= 1'b1;
                        rd <= 1'b1;
                        ms <= cpu_pkg::EXEC;
                    end
                end
                cpu_pkg::ABX0,
                cpu_pkg::ABY0: begin
                    ms   <= (ms == cpu_pkg::ABX0) ? cpu_pkg::ABX1 : cpu_pkg::ABY1;
                    tr   <= idx_din[7:0];
                    pc   <= pc_inc;
                    cout <= idx_din[8];
                end
                cpu_pkg::NDY2,
                cpu_pkg::ABX1,
                cpu_pkg::ABY1: begin
                    ms <= lat_next;
                    ea <= {hi_din, tr};
                    rd <= 1'b1;
                    am <= 1'b1;
                end
                cpu_pkg::LAT1: ms <= cpu_pkg::EXEC;
                cpu_pkg::LATX: ms <= cout ? cpu_pkg::LAT1 : cpu_pkg::EXEC;
                cpu_pkg::EXEC: begin
                    if (hop) begin
                        pc <= pc_inc;                            // Past last operand byte
                    end
                    am <= 1'b0;
                    ms <= cpu_pkg::FETCH;
                end
                cpu_pkg::REL: begin
                    if (ctrl.br) begin
                        pc <= pc_rel;
                        ms <= (pc_rel[15:8] == pc_inc[15:8]) ? cpu_pkg::REL2 : cpu_pkg::REL1;
                    end else begin
                        pc <= pc_inc;
                        ms <= cpu_pkg::FETCH;
                    end
                end
                cpu_pkg::REL1: ms <= cpu_pkg::REL2;              // Page cross
                default:       ms <= cpu_pkg::FETCH;             // REL2 and unused codes
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Register write back
    always_ff @(posedge CLK) begin
        if (rst) begin
            a <= 8'h00;
            x <= 8'h00;
            y <= 8'h00;
            s <= 8'hFF;
            p <= 8'h00;
        end else if (ce) begin
            if (ctrl.wr) begin
                case (ctrl.ra)
                    cpu_pkg::SEL_AD: a <= alu_res;
                    cpu_pkg::SEL_X:  x <= alu_res;
                    cpu_pkg::SEL_Y:  y <= alu_res;
                    default:         a <= a;                     // Zero port, no target
                endcase
            end
            if (ctrl.fw) begin
                p <= alu_flags;
            end
            if (ctrl.sw) begin
                s <= alu_res;
            end
        end
    end

endmodule

/* hdl/cpu_mem.sv */
module cpu_mem #(
    parameter int MEM_AW = 12
) (
    input  logic              CLK,
    input  logic              ce,
    input  cpu_pkg::mem_req_t bus,
    input  logic              load_en,
    input  logic [15:0]       load_addr,
    input  logic [7:0]        load_data,
    output logic [7:0]        rdata
);

    logic [7:0]        mem [2**MEM_AW];         // Upper address bits mirror
    logic [MEM_AW-1:0] bus_idx;
    logic [MEM_AW-1:0] load_idx;

    assign bus_idx  = bus.addr[MEM_AW-1:0];
    assign load_idx = load_addr[MEM_AW-1:0];

    // Same cycle read for fetch and operands
    assign rdata = mem[bus_idx];

    always_ff @(posedge CLK) begin
        if (load_en) begin
            mem[load_idx] <= load_data;         // Program load first
        end else if (ce && bus.we) begin
            mem[bus_idx] <= bus.wdata;
        end
    end

endmodule

/* hdl/cpu_system.sv */
module cpu_system #(
    parameter logic [15:0] RESET_PC = 16'h0400,
    parameter int          MEM_AW   = 12
) (
    input  logic              CLK,
    input  logic              rst,
    input  logic              ce,
    input  logic              load_en,
    input  logic [15:0]       load_addr,
    input  logic [7:0]        load_data,
    output cpu_pkg::mem_req_t bus,
    output logic              rd
);

    logic [7:0] rdata;
    wire        load_wr = load_en && rst;       // Load port only in reset

    cpu_core #(
        .RESET_PC (RESET_PC)
    ) u_core (
        .CLK   (CLK),
        .rst   (rst),
        .ce    (ce),
        .rdata (rdata),
        .bus   (bus),
        .rd    (rd)
    );

    cpu_mem #(
        .MEM_AW (MEM_AW)
    ) u_mem (
        .CLK       (CLK),
        .ce        (ce),
        .bus       (bus),
        .load_en   (load_wr),
        .load_addr (load_addr),
        .load_data (load_data),
        .rdata     (rdata)
    );

endmodule

/* verif/tb_cpu_system.sv */
module tb_cpu_system;

    localparam logic [15:0] RESET_PC = 16'h0400;
    localparam int          NUM_ROWS = 13;       // Six programs, six stall reruns, one reset
    localparam int          MAX_AUX  = 10;
    localparam int          MAX_EXP  = 6;
    localparam int          PERIOD   = 40;

    logic              CLK;
    logic              rst;
    logic              ce;
    logic              load_en;
    logic [15:0]       load_addr;
    logic [7:0]        load_data;
    cpu_pkg::mem_req_t bus;
    logic              rd;

    // Test table, program bytes left aligned at RESET_PC
    logic [191:0] prg      [NUM_ROWS];
    logic [23:0]  aux_tab  [NUM_ROWS][MAX_AUX];  // Address and byte loaded outside the program
    int           n_aux    [NUM_ROWS];
    logic [23:0]  exp_tab  [NUM_ROWS][MAX_EXP];  // Expected write address and data
    int           n_exp    [NUM_ROWS];
    logic         rand_ce  [NUM_ROWS];
    int           rst_at   [NUM_ROWS];           // Writes seen before a mid-run reset

    int                cur_row;
    int                exp_idx;
    logic              rst_q;
    logic              held_valid;
    cpu_pkg::mem_req_t held_bus;
    logic [15:0]       lfsr;

    cpu_system #(
        .RESET_PC (RESET_PC),
        .MEM_AW   (12)
    ) UUT (
        .CLK       (CLK),
        .rst       (rst),
        .ce        (ce),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .bus       (bus),
        .rd        (rd)
    );

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // ------------------------------------------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // Galois taps 16,14,13,11
    endfunction

    task automatic next_cycle;
        @(posedge CLK);
        #5;                                      // Drive after the edge
    endtask

    task automatic add_aux(input int r, input logic [15:0] a, input logic [7:0] d);
        aux_tab[r][n_aux[r]] = {a, d};
        n_aux[r]++;
    endtask

    task automatic add_exp(input int r, input logic [15:0] a, input logic [7:0] d);
        exp_tab[r][n_exp[r]] = {a, d};
        n_exp[r]++;
    endtask

    task automatic copy_row(input int dst, input int src, input logic rce, input int rat);
        int k;
        prg[dst]     = prg[src];
        for (k = 0; k < MAX_AUX; k++) begin
            aux_tab[dst][k] = aux_tab[src][k];
        end
        n_aux[dst]   = n_aux[src];
        for (k = 0; k < MAX_EXP; k++) begin
            exp_tab[dst][k] = exp_tab[src][k];
        end
        n_exp[dst]   = n_exp[src];
        rand_ce[dst] = rce;
        rst_at[dst]  = rat;
    endtask

    task automatic build_table;
        int r;
        for (r = 0; r < NUM_ROWS; r++) begin
            n_aux[r]   = 0;
            n_exp[r]   = 0;
            rand_ce[r] = 1'b0;
            rst_at[r]  = 0;
        end
        // Direct, indexed and page crossing stores
        prg[0] = {96'hA911_A205_A0F0_8520_9520_9630, 96'h8D34_029D_0003_9920_024C_1504};
        add_exp(0, 16'h0020, 8'h11);
        add_exp(0, 16'h0025, 8'h11);
        add_exp(0, 16'h0020, 8'h05);             // zp,Y wraps in zero page
        add_exp(0, 16'h0234, 8'h11);
        add_exp(0, 16'h0305, 8'h11);
        add_exp(0, 16'h0310, 8'h11);             // abs,Y page cross
        // Indirect modes, pointer at FFh wraps to 00h
        prg[1] = {96'hA95A_A201_A020_81FE_9110_8C50, 96'h0294_708E_6002_4C12_0400_0000};
        add_aux(1, 16'h00FF, 8'h40);
        add_aux(1, 16'h0000, 8'h02);
        add_aux(1, 16'h0010, 8'hF0);
        add_aux(1, 16'h0011, 8'h02);
        add_exp(1, 16'h0240, 8'h5A);
        add_exp(1, 16'h0310, 8'h5A);
        add_exp(1, 16'h0250, 8'h20);
        add_exp(1, 16'h0071, 8'h20);
        add_exp(1, 16'h0260, 8'h01);
        // ALU chain, carry out seen through ADC #0
        prg[2] = {96'h1869_7F38_E910_8540_29F0_0905, 96'h49FF_6980_6900_8541_4C14_0400};
        add_exp(2, 16'h0040, 8'h6F);
        add_exp(2, 16'h0041, 8'h1C);
        // Transfers, inc and dec with wrap
        prg[3] = {96'hA901_AA9A_CACA_8AA8_C888_E88A, 96'h8560_9885_61BA_8662_4C14_0400};
        add_exp(3, 16'h0060, 8'h00);
        add_exp(3, 16'h0061, 8'hFF);
        add_exp(3, 16'h0062, 8'h01);             // S via TXS then TSX
        // CPY and BIT with branches
        prg[4] = {96'hA005_C006_B002_8470_3002_8471, 96'h2480_7002_8472_8673_4C14_0400};
        add_aux(4, 16'h0080, 8'hC0);
        add_exp(4, 16'h0070, 8'h05);             // BCS not taken
        add_exp(4, 16'h0073, 8'h00);             // BMI and BVS taken
        // CMP, CPX, loop and page crossing branch
        prg[5] = {96'hA940_C940_F002_8574_A203_CAD0, 96'hFDE0_0190_0286_7586_764C_FA04};
        add_aux(5, 16'h04FA, 8'hA9);
        add_aux(5, 16'h04FB, 8'h55);
        add_aux(5, 16'h04FC, 8'hD0);
        add_aux(5, 16'h04FD, 8'h04);             // Target 0502h
        add_aux(5, 16'h0502, 8'h85);
        add_aux(5, 16'h0503, 8'h77);
        add_aux(5, 16'h0504, 8'h4C);
        add_aux(5, 16'h0505, 8'h04);
        add_aux(5, 16'h0506, 8'h05);
        add_exp(5, 16'h0076, 8'h00);             // Loop count down to zero
        add_exp(5, 16'h0077, 8'h55);
        for (r = 0; r < 6; r++) begin
            copy_row(r + 6, r, 1'b1, 0);
        end
        copy_row(12, 0, 1'b0, 2);
    endtask

    // ------------------------------------------------------------------
    task automatic run_row(input int r);
        int i;
        logic done_rst;
        done_rst = 1'b0;
        rst      = 1'b1;
        ce       = 1'b1;
        for (i = 0; i < 24; i++) begin
            load_en   = 1'b1;
            load_addr = RESET_PC + 16'(i);
            load_data = prg[r][191 - 8 * i -: 8];
            next_cycle();
        end
        for (i = 0; i < n_aux[r]; i++) begin
            load_addr = aux_tab[r][i][23:8];
            load_data = aux_tab[r][i][7:0];
            next_cycle();
        end
        load_en = 1'b0;
        cur_row = r;
        exp_idx = 0;
        repeat (3) next_cycle();
        rst = 1'b0;
        while (exp_idx < n_exp[r]) begin
            next_cycle();
            if (rst_at[r] != 0 && exp_idx == rst_at[r] && !done_rst) begin
                done_rst = 1'b1;
                rst      = 1'b1;                 // Mid-program reset
                ce       = 1'b1;
                repeat (3) next_cycle();
                exp_idx  = 0;
                rst      = 1'b0;
            end else if (rand_ce[r]) begin
                ce   = lfsr[0];
                lfsr = lfsr_next(lfsr);
            end else begin
                ce = 1'b1;
            end
        end
        ce = 1'b1;
        repeat (4) next_cycle();                 // Catch a stray write
    endtask

    // Write monitor, sampled at the edge
    always @(posedge CLK) begin
        if (held_valid) begin
            assert (bus == held_bus) else begin
                $display("mismatch bus: got %h expected %h", bus, held_bus);
                report_failure("stalled write changed on the bus");
            end
        end
        held_valid = 1'b0;
        assert (!(bus.we && (rst || rst_q))) else begin
            report_failure("write strobe during reset or in the first cycle after it");
        end
        assert (!(rd && rst_q)) else begin
            report_failure("read strobe high during reset or in the first cycle after it");
        end
        if (bus.we && ce) begin
            assert (exp_idx < n_exp[cur_row]) else begin
                report_failure("extra memory write beyond the expected sequence");
            end
            assert (bus.addr == exp_tab[cur_row][exp_idx][23:8]) else begin
                $display("mismatch bus.addr: got %h expected %h row %0d",
                         bus.addr, exp_tab[cur_row][exp_idx][23:8], cur_row);
                report_failure("write address wrong");
            end
            assert (bus.wdata == exp_tab[cur_row][exp_idx][7:0]) else begin
                $display("mismatch bus.wdata: got %h expected %h row %0d",
                         bus.wdata, exp_tab[cur_row][exp_idx][7:0], cur_row);
                report_failure("write data wrong");
            end
            exp_idx++;
        end else if (bus.we) begin
            held_valid = 1'b1;                   // Pending until ce
            held_bus   = bus;
        end
        rst_q = rst;
    end

    initial begin
        #(NUM_ROWS * 200 * PERIOD);
        report_failure("watchdog timeout, a row never produced all its writes");
    end

    initial begin
        int r;
        rst        = 1'b1;
        ce         = 1'b1;
        load_en    = 1'b0;
        load_addr  = 16'h0000;
        load_data  = 8'h00;
        rst_q      = 1'b0;                       // No reset edge seen yet
        held_valid = 1'b0;
        cur_row    = 0;
        exp_idx    = 0;
        lfsr       = 16'd48626;
        build_table();
        next_cycle();
        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("No errors");
        $finish;
    end

endmodule

/* sim.f */
hdl/cpu_pkg.sv
hdl/cpu_alu.sv
hdl/cpu_exec_decode.sv
hdl/cpu_core.sv
hdl/cpu_mem.sv
hdl/cpu_system.sv
verif/tb_cpu_system.sv

/* Bender.yml */
package:
  name: cpu_system

sources:
  - files:
      - hdl/cpu_pkg.sv
      - hdl/cpu_alu.sv
      - hdl/cpu_exec_decode.sv
      - hdl/cpu_core.sv
      - hdl/cpu_mem.sv
      - hdl/cpu_system.sv
  - target: test
    files:
      - verif/tb_cpu_system.sv
